// File: verilog.f
src/rx_regs_pkg.sv
src/rx_dsp_pkg.sv
src/rx_ctrl_regs.sv
src/rx_frontend.sv
src/rx_cordic_mixer.sv
src/rx_decimator.sv
src/rx_dsp_top.sv
tests/rx_dsp_props.sv
tests/rx_dsp_tb.sv

// File: Bender.yml
package:
  name: rx_dsp

sources:
  - files:
      - src/rx_regs_pkg.sv
      - src/rx_dsp_pkg.sv
      - src/rx_ctrl_regs.sv
      - src/rx_frontend.sv
      - src/rx_cordic_mixer.sv
      - src/rx_decimator.sv
      - src/rx_dsp_top.sv
  - target: test
    files:
      - tests/rx_dsp_props.sv
      - tests/rx_dsp_tb.sv

// File: tests/rx_dsp_tb.sv
`timescale 1ns/1ps

module rx_dsp_tb;

   localparam int STAGES  = 16;
   localparam int PIPE    = 3 + STAGES + 1;   // Run rise to first sample at the decimator
   localparam int RUN_OVH = 9 * 6 + PIPE + 16;
   localparam int LIMIT   = 40 * 6 + 60 + 6 * (4 * 16 + RUN_OVH) + 4 * (8 * 16 + RUN_OVH)
                            + 8 * (3 * 4 + RUN_OVH) + 3 * (64 + 2 * RUN_OVH) + 2000;

   logic                 clk;
   logic                 rst;
   rx_regs_pkg::wb_req_t wb_req;
   rx_regs_pkg::wb_rsp_t wb_rsp;
   logic [13:0]          adc_a_i;
   logic [13:0]          adc_b_i;
   logic                 adc_ovf_a_i;
   logic                 adc_ovf_b_i;
   logic [15:0]          io_rx_i;
   logic                 run_i;
   rx_dsp_pkg::sample_t  sample_o;
   logic                 strobe_o;

   logic [31:0]          lfsr = 32'hd33f_5904;
   int                   errors = 0;
   int                   checks = 0;
   int                   strobe_cnt = 0;
   rx_dsp_pkg::sample_t  words [$];

   // Model copy of the configuration
   logic [13:0]          m_adc_a, m_adc_b;
   logic signed [13:0]   m_ofs_a, m_ofs_b;
   logic signed [15:0]   m_scale_i, m_scale_q;
   logic [7:0]           m_decim;
   logic [31:0]          m_inc;
   logic [1:0]           m_sel_i, m_sel_q, m_gpio;
   logic [15:0]          m_io;

   rx_dsp_top rx_dsp_top_i (
      .clk(clk), .rst(rst), .wb_req_i(wb_req), .adc_a_i(adc_a_i), .adc_ovf_a_i(adc_ovf_a_i),
      .adc_b_i(adc_b_i), .adc_ovf_b_i(adc_ovf_b_i), .io_rx_i(io_rx_i), .run_i(run_i),
      .wb_rsp_o(wb_rsp), .sample_o(sample_o), .strobe_o(strobe_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk)
   begin
      if (strobe_o)
      begin
         words.push_back(sample_o);
         strobe_cnt++;
      end
   end

   // Galois LFSR, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int b = 0; b < n; b++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [31:0] field_mask(input logic [2:0] adr);
      case (adr)
         3'd2:       return 32'h0000_00ff;
         3'd3, 3'd4: return 32'h0000_3fff;
         3'd5:       return 32'h0000_000f;
         3'd6:       return 32'h0000_0003;
         default:    return 32'hffff_ffff;
      endcase
   endfunction

   function automatic logic signed [13:0] pick(input logic [1:0] sel,
                                               input logic signed [13:0] a,
                                               input logic signed [13:0] b);
      if (sel == 2'd0)
         return a;
      else if (sel == 2'd1)
         return b;
      return '0;
   endfunction

   // Offset, routing and gain for the held ADC values
   function automatic rx_dsp_pkg::iq_t frontend_model();
      logic signed [13:0] a, b, si, sq;
      logic signed [29:0] pi, pq;
      rx_dsp_pkg::iq_t    r;
      a  = m_adc_a - m_ofs_a;
      b  = m_adc_b - m_ofs_b;
      si = pick(m_sel_i, a, b);
      sq = pick(m_sel_q, a, b);
      pi = si * m_scale_i;
      pq = sq * m_scale_q;
      r.i = pi[28:5];
      r.q = pq[28:5];
      return r;
   endfunction

   function automatic rx_dsp_pkg::iq_t rotate(input rx_dsp_pkg::iq_t s, input logic [31:0] ph);
      logic signed [25:0] x, y, xt;
      logic signed [31:0] z;
      rx_dsp_pkg::iq_t    r;
      x  = s.i;
      y  = s.q;
      xt = x;
      case (ph[31:30])   // Whole quarter turns first
         2'd1:
         begin
            x = -y;
            y = xt;
         end
         2'd2:
         begin
            x = -x;
            y = -y;
         end
         2'd3:
         begin
            x = y;
            y = -xt;
         end
         default: ;
      endcase
      z = {2'b00, ph[29:0]};
      for (int k = 0; k < STAGES; k++)
      begin
         xt = x;
         if (z[31])
         begin
            x = x + (y >>> k);
            y = y - (xt >>> k);
            z = z + rx_dsp_pkg::CORDIC_ATAN[k];
         end
         else
         begin
            x = x - (y >>> k);
            y = y + (xt >>> k);
            z = z - rx_dsp_pkg::CORDIC_ATAN[k];
         end
      end
      r.i = x[24:1];  // Halved for the CORDIC gain
      r.q = y[24:1];
      return r;
   endfunction

   function automatic rx_dsp_pkg::sample_t model_word(input int k);
      logic signed [31:0]  si, sq;
      rx_dsp_pkg::iq_t     fe, rot;
      rx_dsp_pkg::sample_t w;
      si = '0;
      sq = '0;
      fe = frontend_model();
      for (int n = k * m_decim; n < (k + 1) * m_decim; n++)
      begin
         rot = rotate(fe, 32'(n) * m_inc);
         si  = si + rot.i;
         sq  = sq + rot.q;
      end
      si = si + 32'sh8000;
      sq = sq + 32'sh8000;
      w.i = si[31:16];
      w.q = sq[31:16];
      if (m_gpio[0])
         w.i[0] = m_io[15];
      if (m_gpio[1])
         w.q[0] = m_io[14];
      return w;
   endfunction

   task automatic wb_access(input logic [2:0] adr, input logic we, input logic [31:0] wdat,
                            output logic [31:0] rdat);
      int waited;
      waited = 0;
      @(posedge clk);
      wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
      @(posedge clk);
      while (!wb_rsp.ack && waited < 16)
      begin
         @(posedge clk);
         waited++;
      end
      if (!wb_rsp.ack)
      begin
         $display("Wishbone error at %0t: no ack for address %0d", $time, adr);
         errors++;
      end
      rdat = wb_rsp.dat;
      wb_req <= '0;
      @(posedge clk);
      if (wb_rsp.ack)
      begin
         $display("Wishbone error at %0t: second ack for address %0d", $time, adr);
         errors++;
      end
   endtask

   task automatic wb_write(input logic [2:0] adr, input logic [31:0] wdat);
      logic [31:0] unused;
      wb_access(adr, 1'b1, wdat, unused);
   endtask

   task automatic wb_read_check(input logic [2:0] adr, input logic [31:0] exp);
      logic [31:0] got;
      wb_access(adr, 1'b0, 32'h0, got);
      checks++;
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t: register %0d read %h expected %h", $time, adr, got, exp);
         errors++;
      end
   endtask

   task automatic randomize_cfg(input logic [31:0] inc, input logic [7:0] decim);
      m_adc_a   = rand_bits(14);
      m_adc_b   = rand_bits(14);
      m_ofs_a   = rand_bits(14);
      m_ofs_b   = rand_bits(14);
      m_scale_i = rand_bits(16);
      m_scale_q = rand_bits(16);
      m_sel_i   = 2'd0;
      m_sel_q   = 2'd1;
      m_gpio    = 2'd0;
      m_io      = 16'h0;
      m_inc     = inc;
      m_decim   = decim;
   endtask

   task automatic apply_cfg();
      wb_write(rx_regs_pkg::REG_PHASE_INC, m_inc);
      wb_write(rx_regs_pkg::REG_SCALE, {m_scale_i, m_scale_q});
      wb_write(rx_regs_pkg::REG_DECIM, 32'(m_decim));
      wb_write(rx_regs_pkg::REG_OFS_A, 32'(unsigned'(m_ofs_a)));
      wb_write(rx_regs_pkg::REG_OFS_B, 32'(unsigned'(m_ofs_b)));
      wb_write(rx_regs_pkg::REG_MUX, {28'h0, m_sel_q, m_sel_i});
      wb_write(rx_regs_pkg::REG_GPIO, 32'(m_gpio));
      @(posedge clk);
      adc_a_i <= m_adc_a;
      adc_b_i <= m_adc_b;
      io_rx_i <= m_io;
      repeat (4) @(posedge clk);  // Let the frontend registers fill
   endtask

   task automatic run_and_check(input int nwords);
      words.delete();
      @(posedge clk);
      run_i <= 1'b1;
      while (words.size() < nwords)
         @(posedge clk);
      run_i <= 1'b0;
      repeat (4) @(posedge clk);
      for (int k = 0; k < nwords; k++)
      begin
         checks++;
         if (words[k] !== model_word(k))
         begin
            $display("CHECK FAILED at %0t: word %0d got %h expected %h",
                     $time, k, words[k], model_word(k));
            errors++;
         end
      end
   endtask

   task automatic report(input string name, input int err_start);
      $display("%s: %0d errors", name, errors - err_start);
   endtask

   initial
   begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the run exceeded %0d cycles", LIMIT);
      $display("=== FAIL ===");
      $finish;
   end

   initial
   begin
      int          e0;
      int          n;
      logic [2:0]  adr;
      logic [31:0] dat;
      logic [1:0]  pairs [0:1][0:1];
      rst = 1'b1;
      wb_req = '0;
      adc_a_i = '0;
      adc_b_i = '0;
      adc_ovf_a_i = 1'b0;
      adc_ovf_b_i = 1'b0;
      io_rx_i = '0;
      run_i = 1'b0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      e0 = errors;
      for (int t = 0; t < 20; t++)
      begin
         adr = 3'(rand_bits(8) % 7);
         dat = rand_bits(32);
         wb_write(adr, dat);
         wb_read_check(adr, dat & field_mask(adr));
      end
      report("test 1 register access", e0);

      e0 = errors;
      @(posedge clk) adc_ovf_a_i <= 1'b1;
      @(posedge clk) adc_ovf_a_i <= 1'b0;
      wb_read_check(rx_regs_pkg::REG_STATUS, 32'h1);
      @(posedge clk) adc_ovf_b_i <= 1'b1;
      @(posedge clk) adc_ovf_b_i <= 1'b0;
      wb_read_check(rx_regs_pkg::REG_STATUS, 32'h3);
      wb_read_check(rx_regs_pkg::REG_STATUS, 32'h3);
      wb_write(rx_regs_pkg::REG_STATUS, 32'h0);
      wb_read_check(rx_regs_pkg::REG_STATUS, 32'h0);
      report("test 2 overflow flags", e0);

      e0 = errors;
      for (int t = 0; t < 6; t++)
      begin
         randomize_cfg(32'h0, 8'(2 + rand_bits(8) % 15));
         apply_cfg();
         run_and_check(4);
      end
      report("test 3 zero frequency", e0);

      e0 = errors;
      for (int t = 0; t < 4; t++)
      begin
         randomize_cfg(rand_bits(32) | 32'h1, 8'(2 + rand_bits(8) % 15));
         apply_cfg();
         run_and_check(8);
      end
      report("test 4 mixing", e0);

      e0 = errors;
      pairs[0][0] = 2'd1;  // Swap A and B
      pairs[0][1] = 2'd0;
      pairs[1][0] = 2'd2;  // I muted
      pairs[1][1] = 2'd3;
      for (int p = 0; p < 2; p++)
      begin
         for (int g = 0; g < 4; g++)
         begin
            randomize_cfg(rand_bits(32), 8'd4);
            m_sel_i = pairs[p][0];
            m_sel_q = pairs[p][1];
            m_gpio  = 2'(g);
            m_io    = (p == 0) ? 16'h8000 : 16'hc000;  // Zero words show both GPIO bits
            apply_cfg();
            run_and_check(3);
         end
      end
      report("test 5 routing and gpio", e0);

      e0 = errors;
      for (int t = 0; t < 3; t++)
      begin
         randomize_cfg(rand_bits(32), 8'(2 + rand_bits(8) % 15));
         apply_cfg();
         n = 8 + rand_bits(8) % 56;
         strobe_cnt = 0;
         repeat (30) @(posedge clk);
         checks++;
         if (strobe_cnt != 0)
         begin
            $display("CHECK FAILED at %0t: %0d strobes with run low", $time, strobe_cnt);
            errors++;
         end
         @(posedge clk);
         run_i <= 1'b1;
         repeat (PIPE + n) @(posedge clk);
         run_i <= 1'b0;
         repeat (8) @(posedge clk);
         checks++;
         if (strobe_cnt != n / m_decim)
         begin
            $display("CHECK FAILED at %0t: %0d strobes for %0d samples, expected %0d",
                     $time, strobe_cnt, n, n / m_decim);
            errors++;
         end
      end
      report("test 6 run gating", e0);

      $display("tests 6, checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: tests/rx_dsp_props.sv
`timescale 1ns/1ps

module rx_dsp_props #(
   parameter int DEPTH = 21  // Frontend, CORDIC and dump latency
) (
   input logic                 clk,
   input logic                 rst,
   input rx_regs_pkg::wb_req_t wb_req_i,
   input rx_regs_pkg::wb_rsp_t wb_rsp_o,
   input logic                 run_i,
   input logic                 strobe_o,
   input logic [7:0]           decim_i
);

   int unsigned low_cnt;  // Cycles with run_i low, saturating

   always_ff @(posedge clk)
   begin
      if (rst || run_i)
         low_cnt <= 0;
      else if (low_cnt < 1000)
         low_cnt <= low_cnt + 1;
   end

   ack_single: assert property (@(posedge clk) disable iff (rst)
      wb_rsp_o.ack |=> !wb_rsp_o.ack)
      else $error("ack held for more than one cycle");

   ack_after_req: assert property (@(posedge clk) disable iff (rst)
      wb_rsp_o.ack |-> $past(wb_req_i.cyc && wb_req_i.stb))
      else $error("ack without a request");

   idle_no_strobe: assert property (@(posedge clk) disable iff (rst)
      (low_cnt > DEPTH) |-> !strobe_o)
      else $error("strobe while run_i is low");

   strobe_spacing: assert property (@(posedge clk) disable iff (rst)
      (strobe_o && decim_i >= 2) |=> !strobe_o)
      else $error("strobe on consecutive cycles");

endmodule

bind rx_dsp_top rx_dsp_props rx_dsp_props_i (
   .clk(clk), .rst(rst), .wb_req_i(wb_req_i), .wb_rsp_o(wb_rsp_o),
   .run_i(run_i), .strobe_o(strobe_o), .decim_i(cfg.decim)
);

// File: src/rx_dsp_top.sv
`timescale 1ns/1ps

module rx_dsp_top #(
   parameter int DECIM_W = 8,
   parameter int STAGES  = 16   // 8 to MAX_STAGES
) (
   input  logic                         clk,
   input  logic                         rst,
   input  rx_regs_pkg::wb_req_t         wb_req_i,
   input  logic [rx_dsp_pkg::ADC_W-1:0] adc_a_i,
   input  logic                         adc_ovf_a_i,
   input  logic [rx_dsp_pkg::ADC_W-1:0] adc_b_i,
   input  logic                         adc_ovf_b_i,
   input  logic [15:0]                  io_rx_i,
   input  logic                         run_i,
   output rx_regs_pkg::wb_rsp_t         wb_rsp_o,
   output rx_dsp_pkg::sample_t          sample_o,
   output logic                         strobe_o
);

   rx_regs_pkg::rx_cfg_t cfg;
   rx_dsp_pkg::iq_t      fe_iq;
   logic                 fe_valid;
   rx_dsp_pkg::iq_t      mix_iq;
   logic                 mix_valid;

   rx_ctrl_regs #(.DECIM_W(DECIM_W)) rx_ctrl_regs_i (
      .clk(clk), .rst(rst), .wb_req_i(wb_req_i),
      .adc_ovf_a_i(adc_ovf_a_i), .adc_ovf_b_i(adc_ovf_b_i),
      .wb_rsp_o(wb_rsp_o), .cfg_o(cfg)
   );

   rx_frontend rx_frontend_i (
      .clk(clk), .rst(rst), .run_i(run_i), .cfg_i(cfg),
      .adc_a_i(adc_a_i), .adc_b_i(adc_b_i), .iq_o(fe_iq), .valid_o(fe_valid)
   );

   rx_cordic_mixer #(.STAGES(STAGES)) rx_cordic_mixer_i (
      .clk(clk), .rst(rst), .run_i(run_i), .cfg_i(cfg),
      .iq_i(fe_iq), .valid_i(fe_valid), .iq_o(mix_iq), .valid_o(mix_valid)
   );

   rx_decimator #(.DECIM_W(DECIM_W)) rx_decimator_i (
      .clk(clk), .rst(rst), .run_i(run_i), .cfg_i(cfg), .iq_i(mix_iq),
      .valid_i(mix_valid), .io_rx_i(io_rx_i), .sample_o(sample_o), .strobe_o(strobe_o)
   );

endmodule

// File: src/rx_decimator.sv
`timescale 1ns/1ps

module rx_decimator #(
   parameter int DECIM_W = 8
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 run_i,
   input  rx_regs_pkg::rx_cfg_t cfg_i,
   input  rx_dsp_pkg::iq_t      iq_i,
   input  logic                 valid_i,
   input  logic [15:0]          io_rx_i,
   output rx_dsp_pkg::sample_t  sample_o,
   output logic                 strobe_o
);

   localparam int ACC_W = 32;
   localparam int OUT_W = rx_dsp_pkg::OUT_W;

   logic [DECIM_W-1:0]      cnt_q;
   logic [DECIM_W-1:0]      last_cnt;
   logic signed [ACC_W-1:0] acc_i_q;
   logic signed [ACC_W-1:0] acc_q_q;
   logic signed [ACC_W-1:0] sum_i;
   logic signed [ACC_W-1:0] sum_q;
   logic [OUT_W-1:0]        rnd_i;
   logic [OUT_W-1:0]        rnd_q;
   logic                    dump;
   rx_dsp_pkg::sample_t     sample_q;
   logic                    strobe_q;

   function automatic logic [OUT_W-1:0] round_sum(input logic signed [ACC_W-1:0] s);
      logic [ACC_W-1:0] r;
      r = s + (ACC_W'(1) << (ACC_W - OUT_W - 1));  // Add half an output LSB
      return r[ACC_W-1 -: OUT_W];
   endfunction

   assign last_cnt = DECIM_W'(cfg_i.decim) - 1'b1;
   assign dump     = valid_i && (cnt_q == last_cnt);
   assign sum_i    = acc_i_q + iq_i.i;
   assign sum_q    = acc_q_q + iq_i.q;

   // GPIO bits take over the LSBs when enabled
   always_comb
   begin
      rnd_i = round_sum(sum_i);
      rnd_q = round_sum(sum_q);
      if (cfg_i.gpio_ena[0])
         rnd_i[0] = io_rx_i[15];
      if (cfg_i.gpio_ena[1])
         rnd_q[0] = io_rx_i[14];
   end

   always_ff @(posedge clk)
   begin
      if (rst || !run_i)
      begin
         cnt_q    <= '0;
         acc_i_q  <= '0;
         acc_q_q  <= '0;
         strobe_q <= 1'b0;
      end
      else
      begin
         strobe_q <= dump;
         if (dump)  // Restart with the next sample
         begin
            cnt_q   <= '0;
            acc_i_q <= '0;
            acc_q_q <= '0;
         end
         else if (valid_i)
         begin
            cnt_q   <= cnt_q + 1'b1;
            acc_i_q <= sum_i;
            acc_q_q <= sum_q;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (dump)
         sample_q <= '{i: rnd_i, q: rnd_q};
   end

   assign sample_o = sample_q;
   assign strobe_o = strobe_q;

endmodule

// File: src/rx_cordic_mixer.sv
`timescale 1ns/1ps

module rx_cordic_mixer #(
   parameter int STAGES = 16
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 run_i,
   input  rx_regs_pkg::rx_cfg_t cfg_i,
   input  rx_dsp_pkg::iq_t      iq_i,
   input  logic                 valid_i,
   output rx_dsp_pkg::iq_t      iq_o,
   output logic                 valid_o
);

   localparam int CW   = rx_dsp_pkg::CORDIC_W;
   localparam int IQ_W = rx_dsp_pkg::IQ_W;

   logic [31:0]          phase_q;
   logic signed [CW-1:0] x_in;
   logic signed [CW-1:0] y_in;
   logic signed [CW-1:0] x_q [0:STAGES];
   logic signed [CW-1:0] y_q [0:STAGES];
   logic signed [31:0]   z_q [0:STAGES-1];
   logic [STAGES:0]      vld_q;

   assign x_in = {{(CW-IQ_W){iq_i.i[IQ_W-1]}}, iq_i.i};
   assign y_in = {{(CW-IQ_W){iq_i.q[IQ_W-1]}}, iq_i.q};

   // Phase of the current sample, zero for the first one after run
   always_ff @(posedge clk)
   begin
      if (rst || !run_i)
         phase_q <= '0;
      else if (valid_i)
         phase_q <= phase_q + cfg_i.phase_inc;
   end

   // Quarter turn pre-rotation
   always_ff @(posedge clk)
   begin
      case (phase_q[31:30])
         2'd0:
         begin
            x_q[0] <= x_in;
            y_q[0] <= y_in;
         end
         2'd1:
         begin
            x_q[0] <= -y_in;
            y_q[0] <= x_in;
         end
         2'd2:
         begin
            x_q[0] <= -x_in;
            y_q[0] <= -y_in;
         end
         default:
         begin
            x_q[0] <= y_in;
            y_q[0] <= -x_in;
         end
      endcase
      z_q[0] <= {2'b00, phase_q[29:0]};  // Residual below a quarter turn
   end

   for (genvar k = 0; k < STAGES; k++)
   begin : g_stage
      always_ff @(posedge clk)
      begin
         if (z_q[k][31])  // Overshot, rotate back
         begin
            x_q[k+1] <= x_q[k] + (y_q[k] >>> k);
            y_q[k+1] <= y_q[k] - (x_q[k] >>> k);
         end
         else
         begin
            x_q[k+1] <= x_q[k] - (y_q[k] >>> k);
            y_q[k+1] <= y_q[k] + (x_q[k] >>> k);
         end
      end

      // Last stage needs no angle update
      if (k < STAGES - 1)
      begin : g_angle
         always_ff @(posedge clk)
         begin
            if (z_q[k][31])
               z_q[k+1] <= z_q[k] + rx_dsp_pkg::CORDIC_ATAN[k];
            else
               z_q[k+1] <= z_q[k] - rx_dsp_pkg::CORDIC_ATAN[k];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst || !run_i)
         vld_q <= '0;
      else
         vld_q <= {vld_q[STAGES-1:0], valid_i};
   end

   // Halve to offset the CORDIC gain
   assign iq_o    = '{i: x_q[STAGES][IQ_W:1], q: y_q[STAGES][IQ_W:1]};
   assign valid_o = vld_q[STAGES];

endmodule

// File: src/rx_frontend.sv
`timescale 1ns/1ps

module rx_frontend (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         run_i,
   input  rx_regs_pkg::rx_cfg_t         cfg_i,
   input  logic [rx_dsp_pkg::ADC_W-1:0] adc_a_i,
   input  logic [rx_dsp_pkg::ADC_W-1:0] adc_b_i,
   output rx_dsp_pkg::iq_t              iq_o,
   output logic                         valid_o
);

   localparam int ADC_W    = rx_dsp_pkg::ADC_W;
   localparam int IQ_W     = rx_dsp_pkg::IQ_W;
   localparam int PROD_W   = ADC_W + 16;
   localparam int PROD_LSB = 5;         // Keeps product bits 28:5

   logic signed [ADC_W-1:0]  a_ofs_q;
   logic signed [ADC_W-1:0]  b_ofs_q;
   logic signed [ADC_W-1:0]  i_sel_q;
   logic signed [ADC_W-1:0]  q_sel_q;
   logic signed [PROD_W-1:0] prod_i;
   logic signed [PROD_W-1:0] prod_q;
   rx_dsp_pkg::iq_t          iq_q;
   logic [2:0]               vld_q;

   function automatic logic signed [ADC_W-1:0] route(
      input logic [1:0]              sel,
      input logic signed [ADC_W-1:0] a,
      input logic signed [ADC_W-1:0] b
   );
      case (sel)
         rx_regs_pkg::SEL_ADC_A: route = a;
         rx_regs_pkg::SEL_ADC_B: route = b;
         default:                route = '0;  // Muted path
      endcase
   endfunction

   // Offset removal, wraps at 14 bits
   always_ff @(posedge clk)
   begin
      a_ofs_q <= adc_a_i - cfg_i.ofs_a;
      b_ofs_q <= adc_b_i - cfg_i.ofs_b;
   end

   always_ff @(posedge clk)
   begin
      i_sel_q <= route(cfg_i.sel_i, a_ofs_q, b_ofs_q);
      q_sel_q <= route(cfg_i.sel_q, a_ofs_q, b_ofs_q);
   end

   assign prod_i = i_sel_q * $signed(cfg_i.scale_i);
   assign prod_q = q_sel_q * $signed(cfg_i.scale_q);

   always_ff @(posedge clk)
   begin
      iq_q.i <= prod_i[PROD_LSB +: IQ_W];
      iq_q.q <= prod_q[PROD_LSB +: IQ_W];
   end

   // Valid follows run_i through the three stages
   always_ff @(posedge clk)
   begin
      if (rst || !run_i)
         vld_q <= '0;
      else
         vld_q <= {vld_q[1:0], 1'b1};
   end

   assign iq_o    = iq_q;
   assign valid_o = vld_q[2];

endmodule

// File: src/rx_ctrl_regs.sv
`timescale 1ns/1ps

module rx_ctrl_regs #(
   parameter int DECIM_W = 8
) (
   input  logic                 clk,
   input  logic                 rst,
   input  rx_regs_pkg::wb_req_t wb_req_i,
   input  logic                 adc_ovf_a_i,
   input  logic                 adc_ovf_b_i,
   output rx_regs_pkg::wb_rsp_t wb_rsp_o,
   output rx_regs_pkg::rx_cfg_t cfg_o
);

   rx_regs_pkg::rx_cfg_t cfg_q;
   logic                 ack_q;
   logic [31:0]          rdat;
   logic [31:0]          rdat_q;
   logic [1:0]           ovf_q;     // {ovf_b, ovf_a}
   logic                 access;
   logic                 wr;
   logic [DECIM_W-1:0]   decim_wr;

   // New request only while ack is low
   assign access   = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
   assign wr       = access & wb_req_i.we;
   assign decim_wr = wb_req_i.dat[DECIM_W-1:0];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ack_q <= 1'b0;
         cfg_q <= '0;
      end
      else
      begin
         ack_q <= access;
         if (wr)
         begin
            case (wb_req_i.adr)
               rx_regs_pkg::REG_PHASE_INC: cfg_q.phase_inc <= wb_req_i.dat;
               rx_regs_pkg::REG_SCALE:
               begin
                  cfg_q.scale_i <= wb_req_i.dat[31:16];
                  cfg_q.scale_q <= wb_req_i.dat[15:0];
               end
               rx_regs_pkg::REG_DECIM:     cfg_q.decim <= 8'(decim_wr);
               rx_regs_pkg::REG_OFS_A:     cfg_q.ofs_a <= wb_req_i.dat[13:0];
               rx_regs_pkg::REG_OFS_B:     cfg_q.ofs_b <= wb_req_i.dat[13:0];
               rx_regs_pkg::REG_MUX:
               begin
                  cfg_q.sel_i <= wb_req_i.dat[1:0];
                  cfg_q.sel_q <= wb_req_i.dat[3:2];
               end
               rx_regs_pkg::REG_GPIO:      cfg_q.gpio_ena <= wb_req_i.dat[1:0];
               default: ;                  // Status handled below
            endcase
         end
      end
   end

   // Sticky overflow, a status write clears but a same-cycle overflow still lands
   always_ff @(posedge clk)
   begin
      if (rst)
         ovf_q <= '0;
      else if (wr && wb_req_i.adr == rx_regs_pkg::REG_STATUS)
         ovf_q <= {adc_ovf_b_i, adc_ovf_a_i};
      else
         ovf_q <= ovf_q | {adc_ovf_b_i, adc_ovf_a_i};
   end

   always_comb
   begin
      rdat = '0;
      case (wb_req_i.adr)
         rx_regs_pkg::REG_PHASE_INC: rdat = cfg_q.phase_inc;
         rx_regs_pkg::REG_SCALE:     rdat = {cfg_q.scale_i, cfg_q.scale_q};
         rx_regs_pkg::REG_DECIM:     rdat[DECIM_W-1:0] = DECIM_W'(cfg_q.decim);
         rx_regs_pkg::REG_OFS_A:     rdat[13:0] = cfg_q.ofs_a;
         rx_regs_pkg::REG_OFS_B:     rdat[13:0] = cfg_q.ofs_b;
         rx_regs_pkg::REG_MUX:       rdat[3:0] = {cfg_q.sel_q, cfg_q.sel_i};
         rx_regs_pkg::REG_GPIO:      rdat[1:0] = cfg_q.gpio_ena;
         default:                    rdat[1:0] = ovf_q;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (access)
         rdat_q <= rdat;  // Presented with ack
   end

   assign wb_rsp_o = '{ack: ack_q, dat: rdat_q};
   assign cfg_o    = cfg_q;

endmodule

// File: src/rx_dsp_pkg.sv
package rx_dsp_pkg;

   localparam int ADC_W      = 14;
   localparam int IQ_W       = 24;
   localparam int CORDIC_W   = 26;  // Two guard bits for CORDIC gain
   localparam int OUT_W      = 16;
   localparam int MAX_STAGES = 16;

   typedef struct packed {
      logic signed [IQ_W-1:0] i;
      logic signed [IQ_W-1:0] q;
   } iq_t;

   // Output word, I in the upper half
   typedef struct packed {
      logic [OUT_W-1:0] i;
      logic [OUT_W-1:0] q;
   } sample_t;

   // arctan(2^-k) in units of 2^-32 turn
   localparam logic [31:0] CORDIC_ATAN [0:MAX_STAGES-1] = '{
      32'h2000_0000, 32'h12e4_051e, 32'h09fb_385b, 32'h0511_11d4,
      32'h028b_0d43, 32'h0145_d7e1, 32'h00a2_f61e, 32'h0051_7c55,
      32'h0028_be53, 32'h0014_5f2f, 32'h000a_2f98, 32'h0005_17cc,
      32'h0002_8be6, 32'h0001_45f3, 32'h0000_a2fa, 32'h0000_517d
   };

endpackage

// File: src/rx_regs_pkg.sv
package rx_regs_pkg;

   // Wishbone classic request, held by the master until ack
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [2:0]  adr;   // Word address
      logic [31:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic [31:0]        phase_inc;
      logic signed [15:0] scale_i;
      logic signed [15:0] scale_q;
      logic [7:0]         decim;     // Samples per output word
      logic signed [13:0] ofs_a;
      logic signed [13:0] ofs_b;
      logic [1:0]         sel_i;
      logic [1:0]         sel_q;
      logic [1:0]         gpio_ena;  // Bit 0 for I, bit 1 for Q
   } rx_cfg_t;

   localparam logic [2:0] REG_PHASE_INC = 3'd0;
   localparam logic [2:0] REG_SCALE     = 3'd1;  // {scale_i, scale_q}
   localparam logic [2:0] REG_DECIM     = 3'd2;
   localparam logic [2:0] REG_OFS_A     = 3'd3;
   localparam logic [2:0] REG_OFS_B     = 3'd4;
   localparam logic [2:0] REG_MUX       = 3'd5;  // {sel_q, sel_i}
   localparam logic [2:0] REG_GPIO      = 3'd6;
   localparam logic [2:0] REG_STATUS    = 3'd7;  // Sticky {ovf_b, ovf_a}

   // Source codes, 2 and 3 give a zero path
   localparam logic [1:0] SEL_ADC_A = 2'd0;
   localparam logic [1:0] SEL_ADC_B = 2'd1;

endpackage
